//--- merge_pkg.sv
// FIFO depth must be a power of two; scan_period of 4 is meant for simulation, raise it for a board

package merge_pkg;

    // --------------------------------------------------
    // Token and FIFO sizing

    localparam int data_width = 4;
    localparam int seq_width  = data_width - 1;  // Tag bit sits above the count

    localparam int fifo_depth       = 4;
    localparam int fifo_ptr_width   = $clog2(fifo_depth);
    localparam int fifo_count_width = $clog2(fifo_depth + 1);

    localparam logic [fifo_count_width - 1:0] fifo_full = fifo_count_width'(fifo_depth);

    // --------------------------------------------------
    // Arbitration

    // Max consecutive A grants while B is waiting
    localparam int starve_limit = 3;
    localparam int wait_width   = $clog2(starve_limit + 1);

    localparam logic [wait_width - 1:0] wait_limit = wait_width'(starve_limit);

    // --------------------------------------------------
    // Display

    localparam int n_digits    = 8;
    localparam int scan_period = 4;  // Clocks per digit
    localparam int scan_width  = (scan_period > 1) ? $clog2(scan_period) : 1;

    localparam logic [scan_width - 1:0] scan_last   = scan_width'(scan_period - 1);
    localparam logic [n_digits   - 1:0] digit_first = {{(n_digits - 1){1'b0}}, 1'b1};

    localparam logic [7:0] sign_ready_a   = 8'b1000_0000,  // Top bar
                           sign_ready_b   = 8'b0000_0010,  // Middle bar
                           sign_ready_out = 8'b0001_0000,  // Bottom bar
                           sign_nothing   = 8'b0000_0000;

    // Segment a is the MSB, h (dot) the LSB
    function automatic logic [7:0] hex_segments (input logic [data_width - 1:0] value);
        logic [7:0] seg;
        case (value)
        4'h0:    seg = 8'b1111_1100;
        4'h1:    seg = 8'b0110_0000;
        4'h2:    seg = 8'b1101_1010;
        4'h3:    seg = 8'b1111_0010;
        4'h4:    seg = 8'b0110_0110;
        4'h5:    seg = 8'b1011_0110;
        4'h6:    seg = 8'b1011_1110;
        4'h7:    seg = 8'b1110_0000;
        4'h8:    seg = 8'b1111_1110;
        4'h9:    seg = 8'b1111_0110;
        4'ha:    seg = 8'b1110_1110;
        4'hb:    seg = 8'b0011_1110;
        4'hc:    seg = 8'b1001_1100;
        4'hd:    seg = 8'b0111_1010;
        4'he:    seg = 8'b1001_1110;
        default: seg = 8'b1000_1110;  // f
        endcase
        return seg;
    endfunction

endpackage

//--- token_source.sv
// Valid simply follows the key, so a released key may drop valid before a transfer; count wraps

module token_source
(
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             key,
    input  logic                             tag,
    output logic                             src_valid,
    input  logic                             src_ready,
    output logic [merge_pkg::data_width - 1:0] src_data
);

    logic [merge_pkg::seq_width - 1:0] count;
    logic                              xfer;

    assign src_valid = key;
    assign xfer      = src_valid & src_ready;

    // Tag picks the half of the token range
    assign src_data  = {tag, count};

    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (xfer)
            count <= count + 1'b1;  // Wraps after 7
    end

    // --------------------------------------------------
    // Checks

    // Offered token only moves on an accepted handshake
    count_needs_xfer: assert property (
        @(posedge clk) disable iff (reset)
        !xfer |=> $stable(src_data)
    );

endmodule

//--- token_fifo.sv
// Show-ahead FIFO; pointers wrap naturally, so depth must stay a power of two

module token_fifo
(
    input  logic                               clk,
    input  logic                               reset,

    input  logic                               push_valid,
    output logic                               push_ready,
    input  logic [merge_pkg::data_width - 1:0] push_data,

    output logic                               head_valid,
    input  logic                               head_ready,
    output logic [merge_pkg::data_width - 1:0] head_data
);

    logic [merge_pkg::data_width - 1:0] mem [merge_pkg::fifo_depth];

    logic [merge_pkg::fifo_ptr_width   - 1:0] rd_ptr;
    logic [merge_pkg::fifo_ptr_width   - 1:0] wr_ptr;
    logic [merge_pkg::fifo_count_width - 1:0] count;

    logic push;
    logic pop;

    // --------------------------------------------------
    // Handshakes

    assign push_ready = (count != merge_pkg::fifo_full);
    assign head_valid = (count != '0);
    assign head_data  = mem[rd_ptr];  // Oldest entry

    assign push = push_valid & push_ready;
    assign pop  = head_valid & head_ready;

    // --------------------------------------------------
    // Pointers and occupancy

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;

            if (pop)
                rd_ptr <= rd_ptr + 1'b1;

            // Simultaneous push and pop keeps the count
            case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    // --------------------------------------------------
    // Checks

    // A push when full or a pop when empty would take the count out of range
    count_in_range: assert property (
        @(posedge clk) disable iff (reset)
        count <= merge_pkg::fifo_full
    );

    // Pointer distance agrees with the occupancy
    pointers_match_count: assert property (
        @(posedge clk) disable iff (reset)
        (wr_ptr - rd_ptr) == count[merge_pkg::fifo_ptr_width - 1:0]
    );

endmodule

//--- starvation_free_arbiter.sv
// Two inputs only; B may wait through at most starve_limit A grants, output stage is one entry

module starvation_free_arbiter
(
    input  logic                               clk,
    input  logic                               reset,

    input  logic                               a_valid,
    output logic                               a_ready,
    input  logic [merge_pkg::data_width - 1:0] a_data,

    input  logic                               b_valid,
    output logic                               b_ready,
    input  logic [merge_pkg::data_width - 1:0] b_data,

    output logic                               out_valid,
    input  logic                               out_ready,
    output logic [merge_pkg::data_width - 1:0] out_data
);

    logic [merge_pkg::wait_width - 1:0] wait_cnt;  // A grants while B waits

    logic load_en;
    logic pick_a;
    logic pick_b;
    logic grant;

    // --------------------------------------------------
    // Selection

    // Output register free now or drained this cycle
    assign load_en = ~out_valid | out_ready;

    // B wins when alone or when it has waited long enough
    assign pick_b  = b_valid & (~a_valid | (wait_cnt == merge_pkg::wait_limit));
    assign pick_a  = a_valid & ~pick_b;

    assign a_ready = load_en & pick_a;
    assign b_ready = load_en & pick_b;
    assign grant   = a_ready | b_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
            wait_cnt <= '0;
        else if (~b_valid | b_ready)
            wait_cnt <= '0;  // Nobody waiting, or B just served
        else if (a_ready)
            wait_cnt <= wait_cnt + 1'b1;
    end

    // --------------------------------------------------
    // Output stage

    always_ff @(posedge clk)
    begin
        if (reset)
            out_valid <= 1'b0;
        else if (load_en)
            out_valid <= grant;
    end

    always_ff @(posedge clk)
    begin
        if (grant)
            out_data <= pick_b ? b_data : a_data;
    end

    // --------------------------------------------------
    // Checks

    one_grant_within_limit: assert property (
        @(posedge clk) disable iff (reset)
        !(a_ready && b_ready) && (wait_cnt <= merge_pkg::wait_limit)
    );

    // Stalled token is held intact for the sink
    hold_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

endmodule

//--- segment_scanner.sv
// Segments are active high and the digit select is one-hot active high; no dots are driven

module segment_scanner
(
    input  logic                               clk,
    input  logic                               reset,

    input  logic [merge_pkg::data_width - 1:0] a_next,
    input  logic [merge_pkg::data_width - 1:0] b_next,
    input  logic [merge_pkg::data_width - 1:0] out_data,

    input  logic                               a_head_valid,
    input  logic                               b_head_valid,
    input  logic                               out_valid,

    input  logic                               a_ready,
    input  logic                               b_ready,
    input  logic                               out_ready,

    output logic [7:0]                         abcdefgh,
    output logic [merge_pkg::n_digits - 1:0]   digit
);

    logic [merge_pkg::scan_width - 1:0] scan_cnt;
    logic                               scan_step;

    // --------------------------------------------------
    // Digit rotation

    assign scan_step = (scan_cnt == merge_pkg::scan_last);

    always_ff @(posedge clk)
    begin
        if (reset)
            scan_cnt <= '0;
        else if (scan_step)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            digit <= merge_pkg::digit_first;
        else if (scan_step)
            digit <= {digit[merge_pkg::n_digits - 2:0], digit[merge_pkg::n_digits - 1]};
    end

    // --------------------------------------------------
    // Segment pattern for the active digit

    always_comb
    begin
        abcdefgh = merge_pkg::sign_nothing;

        if (digit[0])
        begin
            // Rightmost digit is the merged output
            if (out_valid)
                abcdefgh = merge_pkg::hex_segments(out_data);
        end
        else if (digit[1])
        begin
            // Status bars, one per ready
            if (a_ready)
                abcdefgh = abcdefgh | merge_pkg::sign_ready_a;
            if (b_ready)
                abcdefgh = abcdefgh | merge_pkg::sign_ready_b;
            if (out_ready)
                abcdefgh = abcdefgh | merge_pkg::sign_ready_out;
        end
        else if (digit[3])
        begin
            if (b_head_valid)
                abcdefgh = merge_pkg::hex_segments(b_next);
        end
        else if (digit[4])
        begin
            if (a_head_valid)
                abcdefgh = merge_pkg::hex_segments(a_next);
        end
        // Digit 2 and 5 to 7 stay blank
    end

    // --------------------------------------------------
    // Checks

    // Select stays one-hot across rotations
    digit_one_hot: assert property (
        @(posedge clk) disable iff (reset)
        scan_step |=> $onehot(digit) && (digit != $past(digit))
    );

endmodule

//--- merge_demo_top.sv
// Source A is tagged 0 and B is tagged 1; a_ready and b_ready report FIFO space, not grants

module merge_demo_top
(
    input  logic                               clk,
    input  logic                               reset,

    input  logic                               key_a,
    input  logic                               key_b,

    input  logic                               out_ready,
    output logic                               out_valid,
    output logic [merge_pkg::data_width - 1:0] out_data,

    output logic                               a_ready,
    output logic                               b_ready,

    output logic [7:0]                         abcdefgh,
    output logic [merge_pkg::n_digits - 1:0]   digit
);

    logic                               a_src_valid;
    logic [merge_pkg::data_width - 1:0] a_src_data;
    logic                               a_head_valid;
    logic                               a_pop_ready;
    logic [merge_pkg::data_width - 1:0] a_head_data;

    logic                               b_src_valid;
    logic [merge_pkg::data_width - 1:0] b_src_data;
    logic                               b_head_valid;
    logic                               b_pop_ready;
    logic [merge_pkg::data_width - 1:0] b_head_data;

    // --------------------------------------------------
    // Source A, tokens 0 to 7

    token_source i_a_source
    (
        .clk       (clk),
        .reset     (reset),
        .key       (key_a),
        .tag       (1'b0),
        .src_valid (a_src_valid),
        .src_ready (a_ready),
        .src_data  (a_src_data)
    );

    token_fifo i_a_fifo
    (
        .clk        (clk),
        .reset      (reset),
        .push_valid (a_src_valid),
        .push_ready (a_ready),
        .push_data  (a_src_data),
        .head_valid (a_head_valid),
        .head_ready (a_pop_ready),
        .head_data  (a_head_data)
    );

    // --------------------------------------------------
    // Source B, tokens 8 to f

    token_source i_b_source
    (
        .clk       (clk),
        .reset     (reset),
        .key       (key_b),
        .tag       (1'b1),
        .src_valid (b_src_valid),
        .src_ready (b_ready),
        .src_data  (b_src_data)
    );

    token_fifo i_b_fifo
    (
        .clk        (clk),
        .reset      (reset),
        .push_valid (b_src_valid),
        .push_ready (b_ready),
        .push_data  (b_src_data),
        .head_valid (b_head_valid),
        .head_ready (b_pop_ready),
        .head_data  (b_head_data)
    );

    // --------------------------------------------------
    // Merge and display

    starvation_free_arbiter i_arbiter
    (
        .clk       (clk),
        .reset     (reset),
        .a_valid   (a_head_valid),
        .a_ready   (a_pop_ready),
        .a_data    (a_head_data),
        .b_valid   (b_head_valid),
        .b_ready   (b_pop_ready),
        .b_data    (b_head_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    segment_scanner i_scanner
    (
        .clk          (clk),
        .reset        (reset),
        .a_next       (a_head_data),
        .b_next       (b_head_data),
        .out_data     (out_data),
        .a_head_valid (a_head_valid),
        .b_head_valid (b_head_valid),
        .out_valid    (out_valid),
        .a_ready      (a_ready),
        .b_ready      (b_ready),
        .out_ready    (out_ready),
        .abcdefgh     (abcdefgh),
        .digit        (digit)
    );

endmodule

//--- tb_merge_demo.sv
// Self-checking at each falling edge; expects the small simulation scan_period from the package

module tb_merge_demo;

    localparam int drain_limit  = 40;
    localparam int stall_limit  = 30;
    localparam int random_len   = 300;
    localparam int total_cycles = 5 + 20 + 20 + 40 + random_len + 5 * drain_limit + stall_limit;

    // abcdefgh patterns for 0 to f
    localparam logic [7:0] seg_table [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

    logic clk;
    logic reset;
    logic key_a;
    logic key_b;
    logic out_ready;
    logic out_valid;
    logic [merge_pkg::data_width - 1:0] out_data;
    logic a_ready;
    logic b_ready;
    logic [7:0] abcdefgh;
    logic [merge_pkg::n_digits - 1:0] digit;

    // Reference state, mirrors what the DUT holds after the next edge
    logic [merge_pkg::data_width - 1:0] qa [$];
    logic [merge_pkg::data_width - 1:0] qb [$];
    logic [merge_pkg::seq_width - 1:0]  seq_a;
    logic [merge_pkg::seq_width - 1:0]  seq_b;
    logic [merge_pkg::data_width - 1:0] mo_data;
    logic mo_valid;
    logic mo_b_waited;  // B was queued when this A token was granted
    int   wait_cnt;
    int   a_streak;
    int   ticks;
    int   pushes_a;
    int   pushes_b;

    string       test_name;
    logic [31:0] rng;

    merge_demo_top UUT
    (
        .clk       (clk),
        .reset     (reset),
        .key_a     (key_a),
        .key_b     (key_b),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .a_ready   (a_ready),
        .b_ready   (b_ready),
        .abcdefgh  (abcdefgh),
        .digit     (digit)
    );

    always #4 clk = ~clk;

    // --------------------------------------------------
    // Helpers

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Arbitration rule, bit 0 grants A and bit 1 grants B
    function automatic logic [1:0] pick_source(input int a_count, input int b_count,
                                               input int waited);
        logic pick_b;
        pick_b = (b_count > 0) && ((a_count == 0) || (waited == merge_pkg::starve_limit));
        return {pick_b, (a_count > 0) && !pick_b};
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_token(input string what, input logic [merge_pkg::data_width - 1:0] exp,
                               input logic [merge_pkg::data_width - 1:0] act);
        if (act !== exp)
            fail_now($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
    endtask

    task automatic check_segments(input string what, input logic [7:0] exp,
                                  input logic [7:0] act);
        if (act !== exp)
            fail_now($sformatf("ERR %s %s expected %b actual %b", test_name, what, exp, act));
    endtask

    task automatic check_digit(input string what, input logic [merge_pkg::n_digits - 1:0] exp,
                               input logic [merge_pkg::n_digits - 1:0] act);
        if (act !== exp)
            fail_now($sformatf("ERR %s %s expected %b actual %b", test_name, what, exp, act));
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp)
            fail_now($sformatf("ERR %s %s expected %b actual %b", test_name, what, exp, act));
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp)
            fail_now($sformatf("ERR %s %s expected %0d actual %0d", test_name, what, exp, act));
    endtask

    // --------------------------------------------------
    // Reference model and compare, half a cycle before each edge

    always @(negedge clk)
    begin : reference_check
        logic [1:0] pick;
        logic       a_rdy;
        logic       b_rdy;
        logic       load;
        logic [7:0] exp_seg;
        logic [merge_pkg::n_digits - 1:0] exp_digit;
        int         idx;

        if (reset)
        begin
            qa.delete();
            qb.delete();
            seq_a    = '0;
            seq_b    = '0;
            mo_valid = 1'b0;
            wait_cnt = 0;
            a_streak = 0;
            ticks    = 0;
        end
        else
        begin
            a_rdy = (qa.size() < merge_pkg::fifo_depth);
            b_rdy = (qb.size() < merge_pkg::fifo_depth);

            check_flag("out_valid", mo_valid, out_valid);
            check_flag("a_ready", a_rdy, a_ready);
            check_flag("b_ready", b_rdy, b_ready);
            if (mo_valid)
                check_token("out_data", mo_data, out_data);

            // Display for the digit active now
            idx       = (ticks / merge_pkg::scan_period) % merge_pkg::n_digits;
            exp_digit = '0;
            exp_digit[idx] = 1'b1;
            exp_seg   = 8'h00;
            case (idx)
            0: if (mo_valid) exp_seg = seg_table[mo_data];
            1: exp_seg = (a_rdy ? merge_pkg::sign_ready_a : 8'h00)
                       | (b_rdy ? merge_pkg::sign_ready_b : 8'h00)
                       | (out_ready ? merge_pkg::sign_ready_out : 8'h00);
            3: if (qb.size() > 0) exp_seg = seg_table[qb[0]];
            4: if (qa.size() > 0) exp_seg = seg_table[qa[0]];
            default: exp_seg = merge_pkg::sign_nothing;
            endcase
            check_digit("digit", exp_digit, digit);
            check_segments($sformatf("abcdefgh digit %0d", idx), exp_seg, abcdefgh);

            // A tokens that overtook a waiting B
            if (mo_valid && out_ready)
            begin
                a_streak = (!out_data[merge_pkg::data_width - 1] && mo_b_waited)
                           ? a_streak + 1 : 0;
                if (a_streak > merge_pkg::starve_limit)
                    fail_now("B was passed over more than starve_limit times in a row");
            end

            pick = pick_source(qa.size(), qb.size(), wait_cnt);
            load = !mo_valid || out_ready;
            if (!(qb.size() > 0) || (load && pick[1]))
                wait_cnt = 0;
            else if (load && pick[0])
                wait_cnt++;

            if (load)
            begin
                mo_valid    = (pick != 2'b00);
                mo_b_waited = (qb.size() > 0);
                if (pick[0])
                    mo_data = qa.pop_front();
                else if (pick[1])
                    mo_data = qb.pop_front();
            end

            if (key_a && a_rdy)
            begin
                qa.push_back({1'b0, seq_a});
                seq_a++;  // Wraps after 7
                pushes_a++;
            end
            if (key_b && b_rdy)
            begin
                qb.push_back({1'b1, seq_b});
                seq_b++;
                pushes_b++;
            end
            ticks++;
        end
    end

    // --------------------------------------------------
    // Stimulus

    task automatic drive(input logic ka, input logic kb, input logic rdy, input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            #1;
            key_a     = ka;
            key_b     = kb;
            out_ready = rdy;
        end
    endtask

    task automatic drain_stream;
        int n;
        n = 0;
        drive(1'b0, 1'b0, 1'b1, 1);
        while (out_valid || mo_valid || (qa.size() > 0) || (qb.size() > 0))
        begin
            if (n == drain_limit)
                fail_now($sformatf("%s: output stream did not drain", test_name));
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    initial
    begin : main
        int start;
        int n;

        clk       = 1'b0;
        reset     = 1'b1;
        key_a     = 1'b0;
        key_b     = 1'b0;
        out_ready = 1'b0;
        pushes_a  = 0;
        pushes_b  = 0;
        rng       = 32'hcc90_6116;
        test_name = "reset";
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("a_ready", 1'b1, a_ready);
        check_flag("b_ready", 1'b1, b_ready);

        test_name = "a only";
        drive(1'b1, 1'b0, 1'b1, 20);
        drain_stream();
        test_name = "b only";
        drive(1'b0, 1'b1, 1'b1, 20);
        drain_stream();
        test_name = "both held";
        drive(1'b1, 1'b1, 1'b1, 40);
        drain_stream();

        // Sink stalled until both FIFOs refuse
        test_name = "stall";
        start = pushes_a + pushes_b;
        drive(1'b1, 1'b1, 1'b0, 1);
        n = 0;
        while (a_ready || b_ready)
        begin
            if (n == stall_limit)
                fail_now("FIFOs never filled while the sink was stalled");
            drive(1'b1, 1'b1, 1'b0, 1);
            n++;
        end
        check_count("accepted while stalled", 2 * merge_pkg::fifo_depth + 1,
                    pushes_a + pushes_b - start);
        drive(1'b1, 1'b1, 1'b0, 4);
        drain_stream();

        test_name = "random traffic";
        repeat (random_len)
        begin
            rng = xorshift(rng);
            drive(rng[0], rng[1] | rng[2], rng[4] | rng[5], 1);
        end
        drain_stream();

        $display("Test passed");
        $finish;
    end

    initial
    begin : watchdog
        #(total_cycles * 8 * 2);
        fail_now("Watchdog expired before the tests finished");
    end

endmodule

//--- flist.f
merge_pkg.sv
token_source.sv
token_fifo.sv
starvation_free_arbiter.sv
segment_scanner.sv
merge_demo_top.sv
tb_merge_demo.sv

//--- Bender.yml
package:
  name: merge_demo

sources:
  - merge_pkg.sv
  - token_source.sv
  - token_fifo.sv
  - starvation_free_arbiter.sv
  - segment_scanner.sv
  - merge_demo_top.sv
  - target: test
    files:
      - tb_merge_demo.sv
